// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = ooo_core_tb
FILELIST  = project.f
LOG       = sim.log
SIM_BIN   = obj_dir/V$(TOP)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: alu_unit.sv
`timescale 1ns/1ns
`include "rob_params.svh"

module alu_unit
	import rob_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     issue_i,
	input  rob_tag_t tag_i,
	input  opcode_e  op_i,
	input  word_t    a_i,
	input  word_t    b_i,
	output logic     done_o,
	output rob_tag_t tag_o,
	output word_t    result_o
);

	word_t alu_res;
	logic  less_than;

	// signed compare for slt
	assign less_than = $signed(a_i) < $signed(b_i);

	always_comb begin
		case (op_i)
			op_add: alu_res = a_i + b_i;
			op_sub: alu_res = a_i - b_i;
			op_and: alu_res = a_i & b_i;
			op_or:  alu_res = a_i | b_i;
			op_xor: alu_res = a_i ^ b_i;
			op_slt: alu_res = {{(`ROB_XLEN-1){1'b0}}, less_than};
			// branch ops never reach this unit
			default: alu_res = '0;
		endcase
	end

	// completion strobe, one cycle after issue
	always_ff @(posedge clk) begin
		if (rst) begin
			done_o <= 1'b0;
		end else begin
			done_o <= issue_i;
		end
	end

	// result and tag only move on a new issue
	always_ff @(posedge clk) begin
		if (issue_i) begin
			tag_o    <= tag_i;
			result_o <= alu_res;
		end
	end

endmodule

// File: branch_unit.sv
`timescale 1ns/1ns
`include "rob_params.svh"

module branch_unit
	import rob_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     issue_i,
	input  rob_tag_t tag_i,
	input  opcode_e  op_i,
	input  word_t    a_i,
	input  word_t    b_i,
	input  word_t    pc_i,
	input  word_t    imm_i,
	input  logic     pred_i,
	output logic     done_o,
	output rob_tag_t tag_o,
	output logic     taken_o,
	output logic     mispredict_o,
	output word_t    target_o,
	output word_t    link_o
);

	logic     cond_taken;
	logic     s1_valid;
	rob_tag_t s1_tag;
	logic     s1_taken;
	logic     s1_pred;
	word_t    s1_jump_pc;
	word_t    s1_next_pc;
	word_t    sel_target;

	// stage one, condition evaluation
	always_comb begin
		case (op_i)
			op_beq:  cond_taken = (a_i == b_i);
			op_blt:  cond_taken = $signed(a_i) < $signed(b_i);
			op_jal:  cond_taken = 1'b1;
			default: cond_taken = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid <= 1'b0;
			done_o   <= 1'b0;
		end else begin
			s1_valid <= issue_i;
			done_o   <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (issue_i) begin
			s1_tag     <= tag_i;
			s1_taken   <= cond_taken;
			s1_pred    <= pred_i;
			s1_jump_pc <= pc_i + imm_i;
			s1_next_pc <= pc_i + word_t'(4);
		end
	end

	// stage two picks where fetch should have gone
	assign sel_target = s1_taken ? s1_jump_pc : s1_next_pc;

	always_ff @(posedge clk) begin
		if (s1_valid) begin
			tag_o        <= s1_tag;
			taken_o      <= s1_taken;
			mispredict_o <= s1_taken != s1_pred;
			target_o     <= sel_target;
			link_o       <= s1_next_pc;
		end
	end

endmodule

// File: ooo_core_sva.sv
`timescale 1ns/1ns
`include "rob_params.svh"

module ooo_core_sva
	import rob_pkg::*;
(
	input logic     clk,
	input logic     rst,
	input logic     dispatch_valid_i,
	input logic     full_i,
	input logic     redirect_valid_i,
	input logic     br_done_i,
	input logic     commit_valid_i,
	input rob_tag_t commit_tag_i,
	input logic     alu_issue_i,
	input logic     br_issue_i,
	input logic     alu_done_i
);

	rob_tag_t last_tag;
	logic     seen_commit;

	// last retired tag for the in-order step check
	always_ff @(posedge clk) begin
		if (rst) begin
			seen_commit <= 1'b0;
			last_tag    <= '0;
		end else if (commit_valid_i) begin
			seen_commit <= 1'b1;
			last_tag    <= commit_tag_i;
		end
	end

	a_no_dispatch_when_full: assert property (@(posedge clk) disable iff (rst)
		full_i |-> !dispatch_valid_i)
		else $error("dispatch while the reorder buffer is full");

	// the resolving branch went into the two-stage pipe two cycles earlier
	a_redirect_needs_branch: assert property (@(posedge clk) disable iff (rst)
		redirect_valid_i |-> br_done_i && $past(br_issue_i, 2))
		else $error("redirect without a branch issued two cycles earlier");

	a_commit_tag_step: assert property (@(posedge clk) disable iff (rst)
		commit_valid_i && seen_commit |-> commit_tag_i == rob_tag_t'(last_tag + 1'b1))
		else $error("commit tag skipped or repeated");

	a_quiet_after_reset: assert property (@(posedge clk)
		$fell(rst) |-> !(commit_valid_i || redirect_valid_i || alu_issue_i ||
		                 br_issue_i || alu_done_i || br_done_i || full_i))
		else $error("control output active right after reset");

endmodule

bind ooo_core_top ooo_core_sva u_sva (
	.clk              (clk),
	.rst              (rst),
	.dispatch_valid_i (dispatch_valid_i),
	.full_i           (full_o),
	.redirect_valid_i (redirect_valid_o),
	.br_done_i        (br_done),
	.commit_valid_i   (commit_valid_o),
	.commit_tag_i     (commit_tag_o),
	.alu_issue_i      (alu_issue),
	.br_issue_i       (br_issue),
	.alu_done_i       (alu_done)
);

// File: ooo_core_tb.sv
`timescale 1ns/1ns
`include "rob_params.svh"

module ooo_core_tb
	import rob_pkg::*;
;

	typedef struct packed {
		rob_tag_t   tag;
		word_t      data;
		logic [4:0] rd;
		logic       wen;
		logic       dcare;
	} commit_exp_t;

	logic clk;
	logic rst;
	logic dispatch_valid;
	opcode_e dispatch_op;
	logic [4:0] dispatch_rd;
	word_t dispatch_pc;
	word_t dispatch_a;
	word_t dispatch_b;
	word_t dispatch_imm;
	logic dispatch_pred;
	logic commit_valid;
	rob_tag_t commit_tag;
	logic [4:0] commit_rd;
	logic commit_wen;
	word_t commit_data;
	logic redirect_valid;
	word_t redirect_pc;
	logic full;

	// stimulus table, one slot per dispatch
	string tbl_name [$];
	opcode_e tbl_op [$];
	logic [4:0] tbl_rd [$];
	word_t tbl_a [$];
	word_t tbl_b [$];
	word_t tbl_pc [$];
	word_t tbl_imm [$];
	logic tbl_pred [$];

	// reference model state
	commit_exp_t exp_q [$];
	string exp_name_q [$];
	word_t red_pc_q [$];
	int red_cyc_q [$];
	string red_name_q [$];
	rob_tag_t model_tag = '0;
	logic [1:0] win = 2'd0;
	int cycle = 0;
	int cycle_limit = 50;

	tb_clock_gen u_clk (.clk_o(clk), .rst_o(rst));

	ooo_core_top DUT (
		.clk (clk), .rst (rst),
		.dispatch_valid_i (dispatch_valid), .dispatch_op_i (dispatch_op),
		.dispatch_rd_i (dispatch_rd), .dispatch_pc_i (dispatch_pc),
		.dispatch_a_i (dispatch_a), .dispatch_b_i (dispatch_b),
		.dispatch_imm_i (dispatch_imm), .dispatch_pred_i (dispatch_pred),
		.commit_valid_o (commit_valid), .commit_tag_o (commit_tag),
		.commit_rd_o (commit_rd), .commit_wen_o (commit_wen),
		.commit_data_o (commit_data), .redirect_valid_o (redirect_valid),
		.redirect_pc_o (redirect_pc), .full_o (full)
	);

	task automatic abort_run();
		$display("Simulation failed");
		$fatal(1, "stopping at the first error");
	endtask

	function automatic word_t expected_alu_result(opcode_e op, word_t a, word_t b);
		case (op)
			op_add: return a + b;
			op_sub: return a - b;
			op_and: return a & b;
			op_or: return a | b;
			op_xor: return a ^ b;
			op_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default: return 32'd0;
		endcase
	endfunction

	function automatic logic branch_taken(opcode_e op, word_t a, word_t b);
		if (op == op_beq) return a == b;
		if (op == op_blt) return $signed(a) < $signed(b);
		return 1'b1;
	endfunction

	task automatic add_entry(input string name, input opcode_e op, input logic [4:0] rd,
			input word_t a, input word_t b, input word_t pc, input word_t imm, input logic pred);
		tbl_name.push_back(name);
		tbl_op.push_back(op);
		tbl_rd.push_back(rd);
		tbl_a.push_back(a);
		tbl_b.push_back(b);
		tbl_pc.push_back(pc);
		tbl_imm.push_back(imm);
		tbl_pred.push_back(pred);
	endtask

	task automatic check_commit(input string name, input rob_tag_t exp_tag, input word_t exp_data,
			input logic [4:0] exp_rd, input logic exp_wen, input logic data_care);
		if (commit_tag !== exp_tag) begin
			$display("[ERROR] %s: tag expected %0d actual %0d", name, exp_tag, commit_tag);
			abort_run();
		end
		if (commit_rd !== exp_rd || commit_wen !== exp_wen) begin
			$display("[ERROR] %s: rd/wen expected %0d/%0b actual %0d/%0b", name,
				exp_rd, exp_wen, commit_rd, commit_wen);
			abort_run();
		end
		if (data_care && commit_data !== exp_data) begin
			$display("[ERROR] %s: data expected %h actual %h", name, exp_data, commit_data);
			abort_run();
		end
	endtask

	task automatic check_redirect(input string name, input word_t exp_pc);
		if (redirect_pc !== exp_pc) begin
			$display("[ERROR] %s: redirect pc expected %h actual %h", name, exp_pc, redirect_pc);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic exp_val, input logic act_val);
		if (act_val !== exp_val) begin
			$display("[ERROR] %s: expected %b actual %b", name, exp_val, act_val);
			abort_run();
		end
	endtask

	// drive one table slot and extend the model, a squashed slot leaves no trace
	task automatic apply_entry(input int i, input logic squash);
		commit_exp_t ent;
		logic taken;
		dispatch_op = tbl_op[i];
		dispatch_rd = tbl_rd[i];
		dispatch_a = tbl_a[i];
		dispatch_b = tbl_b[i];
		dispatch_pc = tbl_pc[i];
		dispatch_imm = tbl_imm[i];
		dispatch_pred = tbl_pred[i];
		dispatch_valid = 1'b1;
		if (!squash) begin
			ent = '{tag: model_tag, data: 32'd0, rd: tbl_rd[i], wen: 1'b0, dcare: 1'b0};
			if (tbl_op[i] == op_beq || tbl_op[i] == op_blt || tbl_op[i] == op_jal) begin
				taken = branch_taken(tbl_op[i], tbl_a[i], tbl_b[i]);
				if (taken != tbl_pred[i]) begin
					win = 2'd1;
					red_pc_q.push_back(taken ? tbl_pc[i] + tbl_imm[i] : tbl_pc[i] + 32'd4);
					red_cyc_q.push_back(cycle + 2);
					red_name_q.push_back(tbl_name[i]);
				end
				if (tbl_op[i] == op_jal) begin
					ent.data = tbl_pc[i] + 32'd4;
					ent.wen = tbl_rd[i] != 5'd0;
					ent.dcare = 1'b1;
				end
			end else begin
				ent.data = expected_alu_result(tbl_op[i], tbl_a[i], tbl_b[i]);
				ent.wen = tbl_rd[i] != 5'd0;
				ent.dcare = 1'b1;
			end
			exp_q.push_back(ent);
			exp_name_q.push_back(tbl_name[i]);
			model_tag = model_tag + 1'b1;
		end
	endtask

	always @(posedge clk) begin
		cycle = cycle + 1;
		if (cycle > cycle_limit) begin
			$display("timeout after %0d cycles, %0d commits still expected", cycle, exp_q.size());
			abort_run();
		end
	end

	// outputs are settled by the falling edge
	always @(negedge clk) begin
		commit_exp_t ent;
		if (!rst && commit_valid) begin
			if (exp_q.size() == 0) begin
				$display("commit of tag %0d arrived with nothing left to retire", commit_tag);
				abort_run();
			end
			ent = exp_q.pop_front();
			check_commit(exp_name_q.pop_front(), ent.tag, ent.data, ent.rd, ent.wen, ent.dcare);
		end
		if (red_cyc_q.size() != 0 && red_cyc_q[0] == cycle) begin
			if (!redirect_valid) begin
				$display("redirect for %s did not appear in its cycle", red_name_q[0]);
				abort_run();
			end
			check_redirect(red_name_q.pop_front(), red_pc_q.pop_front());
			red_cyc_q.delete(0);
		end else if (!rst && redirect_valid) begin
			$display("redirect to %h raised with no mispredicted branch", redirect_pc);
			abort_run();
		end
	end

	initial begin
		int seed_ret;
		int idx;
		logic squash;
		logic hold;
		opcode_e op;
		word_t a;
		dispatch_valid = 1'b0;
		dispatch_op = op_add;
		dispatch_rd = 5'd0;
		dispatch_pc = 32'd0;
		dispatch_a = 32'd0;
		dispatch_b = 32'd0;
		dispatch_imm = 32'd0;
		dispatch_pred = 1'b0;
		seed_ret = $urandom(34638);

		add_entry("add_basic", op_add, 5'd1, 32'd5, 32'd7, 32'h0, 32'h0, 1'b0);
		add_entry("sub_neg", op_sub, 5'd2, 32'd3, 32'd10, 32'h0, 32'h0, 1'b0);
		add_entry("and_mask", op_and, 5'd3, 32'hf0f0_1234, 32'h0ff0_ff00, 32'h0, 32'h0, 1'b0);
		add_entry("or_bits", op_or, 5'd4, 32'h0000_00a0, 32'h0000_000b, 32'h0, 32'h0, 1'b0);
		add_entry("xor_bits", op_xor, 5'd5, 32'hffff_0000, 32'h0f0f_0f0f, 32'h0, 32'h0, 1'b0);
		add_entry("slt_signed", op_slt, 5'd6, 32'hffff_fffb, 32'd3, 32'h0, 32'h0, 1'b0);
		add_entry("slt_false", op_slt, 5'd7, 32'd9, 32'hffff_fff0, 32'h0, 32'h0, 1'b0);
		add_entry("add_rd0", op_add, 5'd0, 32'd11, 32'd22, 32'h0, 32'h0, 1'b0);
		add_entry("beq_pred_ok", op_beq, 5'd0, 32'd4, 32'd4, 32'h100, 32'h40, 1'b1);
		add_entry("add_after_beq", op_add, 5'd8, 32'd100, 32'd1, 32'h0, 32'h0, 1'b0);
		add_entry("blt_nt_ok", op_blt, 5'd0, 32'd9, 32'd2, 32'h140, 32'h20, 1'b0);
		add_entry("beq_mispred", op_beq, 5'd0, 32'd1, 32'd2, 32'h180, 32'h40, 1'b1);
		add_entry("sub_squashed", op_sub, 5'd9, 32'd50, 32'd8, 32'h0, 32'h0, 1'b0);
		add_entry("or_after_flush", op_or, 5'd10, 32'h1, 32'h2, 32'h0, 32'h0, 1'b0);
		add_entry("blt_mispred", op_blt, 5'd0, 32'hffff_fffd, 32'd2, 32'h1c0, 32'h60, 1'b0);
		add_entry("xor_squashed", op_xor, 5'd11, 32'h5, 32'h3, 32'h0, 32'h0, 1'b0);
		add_entry("and_after_flush", op_and, 5'd12, 32'h3c, 32'h0f, 32'h0, 32'h0, 1'b0);
		add_entry("jal_pred_taken", op_jal, 5'd1, 32'h0, 32'h0, 32'h200, 32'h80, 1'b1);
		add_entry("jal_pred_nt", op_jal, 5'd5, 32'h0, 32'h0, 32'h300, 32'hffff_fff0, 1'b0);
		add_entry("add_squashed", op_add, 5'd13, 32'd1, 32'd1, 32'h0, 32'h0, 1'b0);
		add_entry("slt_after_jal", op_slt, 5'd14, 32'd1, 32'd2, 32'h0, 32'h0, 1'b0);
		for (int k = 0; k < 40; k++) begin
			op = opcode_e'(4'($urandom_range(8, 0)));
			a = $urandom();
			add_entry($sformatf("rand_%0d", k), op, 5'($urandom_range(31, 0)), a,
				($urandom_range(3, 0) == 0) ? a : $urandom(), $urandom() & 32'hffff_fffc,
				($urandom() & 32'h0000_0ffc) - 32'h0000_0800, 1'($urandom_range(1, 0)));
		end
		cycle_limit = 8 * tbl_op.size() + 50;

		@(negedge rst);
		@(negedge clk);
		check_flag("reset_commit_valid", 1'b0, commit_valid);
		check_flag("reset_redirect_valid", 1'b0, redirect_valid);
		check_flag("reset_full", 1'b0, full);

		idx = 0;
		while (idx < tbl_op.size()) begin
			@(posedge clk);
			#1;
			dispatch_valid = 1'b0;
			// slot after a mispredict is squashed, the next one is the redirect cycle
			squash = (win == 2'd1);
			hold = (win == 2'd2);
			win = squash ? 2'd2 : 2'd0;
			if (!hold && !full) begin
				apply_entry(idx, squash);
				idx++;
			end
		end
		@(posedge clk);
		#1;
		dispatch_valid = 1'b0;

		while (exp_q.size() != 0 || red_cyc_q.size() != 0) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk);
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// File: ooo_core_top.sv
`timescale 1ns/1ns
`include "rob_params.svh"

module ooo_core_top
	import rob_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       dispatch_valid_i,
	input  opcode_e    dispatch_op_i,
	input  logic [4:0] dispatch_rd_i,
	input  word_t      dispatch_pc_i,
	input  word_t      dispatch_a_i,
	input  word_t      dispatch_b_i,
	input  word_t      dispatch_imm_i,
	input  logic       dispatch_pred_i,
	output logic       commit_valid_o,
	output rob_tag_t   commit_tag_o,
	output logic [4:0] commit_rd_o,
	output logic       commit_wen_o,
	output word_t      commit_data_o,
	output logic       redirect_valid_o,
	output word_t      redirect_pc_o,
	output logic       full_o
);

	logic     alu_issue;
	logic     br_issue;
	rob_tag_t issue_tag;
	logic     alu_done;
	rob_tag_t alu_tag;
	word_t    alu_result;
	logic     br_done;
	rob_tag_t br_tag;
	logic     br_mispredict;
	word_t    br_target;
	word_t    br_link;

	reorder_buffer u_rob (
		.clk              (clk),
		.rst              (rst),
		.dispatch_valid_i (dispatch_valid_i),
		.dispatch_op_i    (dispatch_op_i),
		.dispatch_rd_i    (dispatch_rd_i),
		.alu_issue_o      (alu_issue),
		.br_issue_o       (br_issue),
		.issue_tag_o      (issue_tag),
		.alu_done_i       (alu_done),
		.alu_tag_i        (alu_tag),
		.alu_result_i     (alu_result),
		.br_done_i        (br_done),
		.br_tag_i         (br_tag),
		.br_mispredict_i  (br_mispredict),
		.br_target_i      (br_target),
		.br_link_i        (br_link),
		.commit_valid_o   (commit_valid_o),
		.commit_tag_o     (commit_tag_o),
		.commit_rd_o      (commit_rd_o),
		.commit_wen_o     (commit_wen_o),
		.commit_data_o    (commit_data_o),
		.redirect_valid_o (redirect_valid_o),
		.redirect_pc_o    (redirect_pc_o),
		.full_o           (full_o)
	);

	// operands fan out to both units, each latches on its own issue
	alu_unit u_alu (
		.clk      (clk),
		.rst      (rst),
		.issue_i  (alu_issue),
		.tag_i    (issue_tag),
		.op_i     (dispatch_op_i),
		.a_i      (dispatch_a_i),
		.b_i      (dispatch_b_i),
		.done_o   (alu_done),
		.tag_o    (alu_tag),
		.result_o (alu_result)
	);

	// taken is not needed by the buffer, the mispredict flag carries it
	branch_unit u_br (
		.clk          (clk),
		.rst          (rst),
		.issue_i      (br_issue),
		.tag_i        (issue_tag),
		.op_i         (dispatch_op_i),
		.a_i          (dispatch_a_i),
		.b_i          (dispatch_b_i),
		.pc_i         (dispatch_pc_i),
		.imm_i        (dispatch_imm_i),
		.pred_i       (dispatch_pred_i),
		.done_o       (br_done),
		.tag_o        (br_tag),
		.taken_o      (),
		.mispredict_o (br_mispredict),
		.target_o     (br_target),
		.link_o       (br_link)
	);

endmodule

// File: project.f
+incdir+.
rob_pkg.sv
alu_unit.sv
branch_unit.sv
reorder_buffer.sv
ooo_core_top.sv
tb_clock_gen.sv
ooo_core_sva.sv
ooo_core_tb.sv

// File: reorder_buffer.sv
`timescale 1ns/1ns
`include "rob_params.svh"

module reorder_buffer
	import rob_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       dispatch_valid_i,
	input  opcode_e    dispatch_op_i,
	input  logic [4:0] dispatch_rd_i,
	output logic       alu_issue_o,
	output logic       br_issue_o,
	output rob_tag_t   issue_tag_o,
	input  logic       alu_done_i,
	input  rob_tag_t   alu_tag_i,
	input  word_t      alu_result_i,
	input  logic       br_done_i,
	input  rob_tag_t   br_tag_i,
	input  logic       br_mispredict_i,
	input  word_t      br_target_i,
	input  word_t      br_link_i,
	output logic       commit_valid_o,
	output rob_tag_t   commit_tag_o,
	output logic [4:0] commit_rd_o,
	output logic       commit_wen_o,
	output word_t      commit_data_o,
	output logic       redirect_valid_o,
	output word_t      redirect_pc_o,
	output logic       full_o
);

	typedef logic [`ROB_TAG_W:0] cnt_t;

	// entry storage
	opcode_e               ent_op   [`ROB_DEPTH];
	logic [4:0]            ent_rd   [`ROB_DEPTH];
	word_t                 ent_data [`ROB_DEPTH];
	logic [`ROB_DEPTH-1:0] ent_valid;
	logic [`ROB_DEPTH-1:0] ent_rdy;

	rob_tag_t head;
	rob_tag_t tail;
	cnt_t     count;

	logic     alloc;
	logic     commit;
	logic     flush;
	logic     alu_wb;
	logic     br_wb;
	rob_tag_t br_off;

	function automatic logic is_branch_op(opcode_e op);
		return (op == op_beq) || (op == op_blt) || (op == op_jal);
	endfunction

	// everything except conditional branches writes rd
	function automatic logic writes_rd(opcode_e op);
		return (op != op_beq) && (op != op_blt);
	endfunction

	// a stale result from a squashed branch must not redirect
	assign flush = br_done_i && br_mispredict_i && ent_valid[br_tag_i];

	assign full_o = count[`ROB_TAG_W];

	// dispatch in a redirect cycle is dropped, it belongs to the wrong path
	assign alloc       = dispatch_valid_i && !full_o && !flush;
	assign alu_issue_o = alloc && !is_branch_op(dispatch_op_i);
	assign br_issue_o  = alloc && is_branch_op(dispatch_op_i);
	assign issue_tag_o = tail;

	assign alu_wb = alu_done_i && ent_valid[alu_tag_i];
	assign br_wb  = br_done_i && ent_valid[br_tag_i];

	// age of the resolving branch relative to the head
	assign br_off = br_tag_i - head;

	// head of the buffer retires once its result is in
	assign commit         = ent_valid[head] && ent_rdy[head];
	assign commit_valid_o = commit;
	assign commit_tag_o   = head;
	assign commit_rd_o    = ent_rd[head];
	assign commit_data_o  = ent_data[head];
	assign commit_wen_o   = commit && writes_rd(ent_op[head]) && (ent_rd[head] != 5'd0);

	assign redirect_valid_o = flush;
	assign redirect_pc_o    = br_target_i;

	// head, tail and occupancy
	always_ff @(posedge clk) begin
		if (rst) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (commit) begin
				head <= head + 1'b1;
			end
			if (flush) begin
				// keep everything up to and including the branch
				tail  <= br_tag_i + 1'b1;
				count <= cnt_t'(br_off) + cnt_t'(1) - cnt_t'(commit);
			end else begin
				if (alloc) begin
					tail <= tail + 1'b1;
				end
				count <= count + cnt_t'(alloc) - cnt_t'(commit);
			end
		end
	end

	// per entry valid and ready bits
	always_ff @(posedge clk) begin
		if (rst) begin
			ent_valid <= '0;
			ent_rdy   <= '0;
		end else begin
			for (int i = 0; i < `ROB_DEPTH; i++) begin
				if (alloc && (tail == rob_tag_t'(i))) begin
					ent_valid[i] <= 1'b1;
					ent_rdy[i]   <= 1'b0;
				end
				if ((alu_wb && (alu_tag_i == rob_tag_t'(i))) ||
				    (br_wb && (br_tag_i == rob_tag_t'(i)))) begin
					ent_rdy[i] <= 1'b1;
				end
				if (commit && (head == rob_tag_t'(i))) begin
					ent_valid[i] <= 1'b0;
				end
				// squash anything younger than the mispredicted branch
				if (flush && (rob_tag_t'(rob_tag_t'(i) - head) > br_off)) begin
					ent_valid[i] <= 1'b0;
				end
			end
		end
	end

	// payload, written at allocation and at writeback
	always_ff @(posedge clk) begin
		if (alloc) begin
			ent_op[tail]   <= dispatch_op_i;
			ent_rd[tail]   <= dispatch_rd_i;
			ent_data[tail] <= '0;
		end
		if (alu_wb) begin
			ent_data[alu_tag_i] <= alu_result_i;
		end
		// jal returns its link value, conditional branches leave data alone
		if (br_wb && (ent_op[br_tag_i] == op_jal)) begin
			ent_data[br_tag_i] <= br_link_i;
		end
	end

endmodule

// File: rob_params.svh
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// data path width in bits
`define ROB_XLEN 32

// number of reorder buffer entries, a power of two
`define ROB_DEPTH 8

// tag width is log2 of the depth
`define ROB_TAG_W 3

`endif

// File: rob_pkg.sv
`include "rob_params.svh"

package rob_pkg;

	// decoded operation classes seen by the reorder buffer and the units
	// arithmetic ops go to the alu, the last three to the branch unit
	typedef enum logic [3:0] {
		op_add = 4'd0,
		op_sub = 4'd1,
		op_and = 4'd2,
		op_or  = 4'd3,
		op_xor = 4'd4,
		op_slt = 4'd5,
		op_beq = 4'd6,
		op_blt = 4'd7,
		op_jal = 4'd8
	} opcode_e;

	// index of a reorder buffer entry, wraps modulo the depth
	typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

	// one data word, also used for pc values and offsets
	typedef logic [`ROB_XLEN-1:0] word_t;

endpackage

// File: tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
	parameter int half_period  = 4,
	parameter int reset_cycles = 3
) (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #half_period clk_o = ~clk_o;
	end

	// reset released on a rising edge so it lines up with the first active cycle
	initial begin
		rst_o = 1'b1;
		repeat (reset_cycles) @(posedge clk_o);
		rst_o <= 1'b0;
	end

endmodule
